/* verilog/backend_pkg.sv */
`default_nettype none

package backend_pkg;

    // Datapath widths
    localparam int unsigned WORD_BITS     = 32;
    localparam int unsigned REG_ADDR_BITS = 5;    // 32 architectural registers
    localparam int unsigned BYTE_SEL_BITS = WORD_BITS / 8;
    localparam int unsigned MEM_TYPE_BITS = 3;    // Access size code

    // Issue lanes, lane 0 holds the older instruction
    localparam int unsigned ISSUE_WIDTH = 2;

    // Refetch resumes at the instruction after the idle PC
    localparam int unsigned INSTR_BYTES = 4;

    // Data cache geometry
    localparam int unsigned DCACHE_OFFSET_BITS = 4;    // 16-byte line
    localparam int unsigned DCACHE_INDEX_BITS  = 8;    // Sits right above the offset

    // Debug write enable is wider than the single lane strobe
    localparam int unsigned DEBUG_WEN_BITS = 4;

    typedef logic [WORD_BITS-1:0]     word_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [BYTE_SEL_BITS-1:0] byte_sel_t;
    typedef logic [MEM_TYPE_BITS-1:0] mem_type_t;

    typedef logic [DCACHE_INDEX_BITS-1:0]  dcache_index_t;
    typedef logic [DCACHE_OFFSET_BITS-1:0] dcache_offset_t;

endpackage

`default_nettype wire

/* verilog/redirect_sel.sv */
`timescale 1ns/1ns
`default_nettype none

module redirect_sel #(
    parameter  int unsigned FTQ_DEPTH   = 8,
    localparam int unsigned FTQ_ID_BITS = $clog2(FTQ_DEPTH)
) (
    // Control side flush levels
    input  wire logic                                          excp_flush_i,
    input  wire logic                                          excp_tlbrefill_i,
    input  wire logic                                          ertn_flush_i,
    input  wire logic                                          idle_flush_i,
    input  wire logic                                          fetch_flush_i,
    input  wire logic                                          ex_stall_i,

    // Branch results from the issue lanes
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]           branch_flag_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] branch_target_i,
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0][FTQ_ID_BITS-1:0] branch_ftq_id_i,
    input  wire logic [FTQ_ID_BITS-1:0]                        ctrl_ftq_id_i,

    // Redirect vectors
    input  wire backend_pkg::word_t                            csr_eentry_i,
    input  wire backend_pkg::word_t                            csr_tlbrentry_i,
    input  wire backend_pkg::word_t                            csr_era_i,
    input  wire backend_pkg::word_t                            idle_pc_i,

    output logic                                               flush_o,
    output backend_pkg::word_t                                 next_pc_o,
    output logic [FTQ_ID_BITS-1:0]                             flush_ftq_id_o,
    output logic [backend_pkg::ISSUE_WIDTH-1:0]                branch_taken_o
);

    import backend_pkg::*;

    logic [ISSUE_WIDTH-1:0] branch_taken;
    logic                   ctrl_flush;
    word_t                  branch_pc;
    logic [FTQ_ID_BITS-1:0] branch_id;

    // A stalled EX stage may still be waiting on operands
    assign branch_taken = ex_stall_i ? '0 : branch_flag_i;

    assign ctrl_flush = excp_flush_i | ertn_flush_i | idle_flush_i | fetch_flush_i;

    // Lowest taken lane wins since it is the older instruction
    always_comb begin
        branch_pc = '0;
        branch_id = '0;
        for (int i = ISSUE_WIDTH - 1; i >= 0; i--) begin
            if (branch_taken[i]) begin
                branch_pc = branch_target_i[i];
                branch_id = branch_ftq_id_i[i];
            end
        end
    end

    always_comb begin
        if (excp_flush_i && !excp_tlbrefill_i) begin
            next_pc_o = csr_eentry_i;
        end else if (excp_flush_i) begin
            next_pc_o = csr_tlbrentry_i;    // TLB refill vector
        end else if (ertn_flush_i) begin
            next_pc_o = csr_era_i;
        end else if (idle_flush_i) begin
            next_pc_o = idle_pc_i;
        end else if (fetch_flush_i) begin
            next_pc_o = idle_pc_i + word_t'(INSTR_BYTES);    // Refetch next instr
        end else if (|branch_taken) begin
            next_pc_o = branch_pc;
        end else begin
            next_pc_o = '0;
        end
    end

    assign flush_o = ctrl_flush | (|branch_taken);

    // Control flushes carry the id of the committing block
    assign flush_ftq_id_o = ctrl_flush ? ctrl_ftq_id_i : branch_id;

    assign branch_taken_o = branch_taken;    // To the controller

    // Refill is a flavour of exception raised by the CSR side
    a_refill_with_excp: assert final ($countones(excp_tlbrefill_i & ~excp_flush_i) == 0)
        else $error("redirect_sel: excp_tlbrefill_i without excp_flush_i");

endmodule

`default_nettype wire

/* verilog/lane_mem_merge.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_mem_merge (
    // Memory lane requests
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]               lane_ce_i,
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]               lane_we_i,
    input  wire backend_pkg::byte_sel_t [backend_pkg::ISSUE_WIDTH-1:0] lane_sel_i,
    input  wire backend_pkg::mem_type_t [backend_pkg::ISSUE_WIDTH-1:0] lane_rd_type_i,
    input  wire backend_pkg::mem_type_t [backend_pkg::ISSUE_WIDTH-1:0] lane_wr_type_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] lane_addr_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] lane_wdata_i,
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]               wb_dcache_flush_i,

    // Data cache request port
    output logic                                                   dcache_valid_o,
    output logic                                                   dcache_op_o,
    output backend_pkg::dcache_index_t                             dcache_index_o,
    output backend_pkg::dcache_offset_t                            dcache_offset_o,
    output backend_pkg::byte_sel_t                                 dcache_wstrb_o,
    output backend_pkg::word_t                                     dcache_wdata_o,
    output backend_pkg::mem_type_t                                 dcache_rd_type_o,
    output backend_pkg::mem_type_t                                 dcache_wr_type_o,
    output logic                                                   dcache_flush_o
);

    import backend_pkg::*;

    word_t req_addr;

    assign dcache_valid_o = |lane_ce_i;
    assign dcache_op_o    = |lane_we_i;    // 1 = write

    // Scan from the last lane down so lane 0 has priority
    always_comb begin
        dcache_wstrb_o   = '0;
        dcache_wdata_o   = '0;
        dcache_rd_type_o = '0;
        dcache_wr_type_o = '0;
        req_addr         = '0;
        for (int i = ISSUE_WIDTH - 1; i >= 0; i--) begin
            if (lane_we_i[i]) begin
                dcache_wstrb_o = lane_sel_i[i];
                dcache_wdata_o = lane_wdata_i[i];
            end
            if (lane_ce_i[i]) begin
                dcache_rd_type_o = lane_rd_type_i[i];
                dcache_wr_type_o = lane_wr_type_i[i];
                req_addr         = lane_addr_i[i];
            end
        end
    end

    // Virtual index and line offset, tag comes from the TLB
    assign dcache_offset_o = req_addr[DCACHE_OFFSET_BITS-1:0];
    assign dcache_index_o  = req_addr[DCACHE_OFFSET_BITS +: DCACHE_INDEX_BITS];

    // Exception in either lane drops the cache request
    assign dcache_flush_o = |wb_dcache_flush_i;

    // Single data port, the dispatcher never pairs two memory ops
    a_one_lane: assert final ($countones(lane_ce_i) <= 1)
        else $error("lane_mem_merge: both lanes enabled %b", lane_ce_i);

    a_we_with_ce: assert final ($countones(lane_we_i & ~lane_ce_i) == 0)
        else $error("lane_mem_merge: write enable %b without chip enable %b",
                    lane_we_i, lane_ce_i);

endmodule

`default_nettype wire

/* verilog/wb_debug_trace.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_debug_trace (
    input  wire logic                                              clk,
    input  wire logic                                              reset_i,

    // Register file writes from the controller
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]               wb_we_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] wb_pc_i,
    input  wire backend_pkg::reg_addr_t [backend_pkg::ISSUE_WIDTH-1:0] wb_waddr_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] wb_wdata_i,

    output backend_pkg::word_t                                     debug0_wb_pc_o,
    output logic [backend_pkg::DEBUG_WEN_BITS-1:0]                 debug0_wb_rf_wen_o,
    output backend_pkg::reg_addr_t                                 debug0_wb_rf_wnum_o,
    output backend_pkg::word_t                                     debug0_wb_rf_wdata_o,

    output backend_pkg::word_t                                     debug1_wb_pc_o,
    output logic [backend_pkg::DEBUG_WEN_BITS-1:0]                 debug1_wb_rf_wen_o,
    output backend_pkg::reg_addr_t                                 debug1_wb_rf_wnum_o,
    output backend_pkg::word_t                                     debug1_wb_rf_wdata_o
);

    import backend_pkg::*;

    logic [ISSUE_WIDTH-1:0]      we_q;
    word_t [ISSUE_WIDTH-1:0]     pc_q;
    reg_addr_t [ISSUE_WIDTH-1:0] waddr_q;
    word_t [ISSUE_WIDTH-1:0]     wdata_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            we_q <= '0;
        end else begin
            we_q <= wb_we_i;
        end
    end

    // Payload only matters when the enable is set
    always_ff @(posedge clk) begin
        pc_q    <= wb_pc_i;
        waddr_q <= wb_waddr_i;
        wdata_q <= wb_wdata_i;
    end

    assign debug0_wb_pc_o       = pc_q[0];
    assign debug0_wb_rf_wen_o   = {{(DEBUG_WEN_BITS-1){1'b0}}, we_q[0]};
    assign debug0_wb_rf_wnum_o  = waddr_q[0];
    assign debug0_wb_rf_wdata_o = wdata_q[0];

    assign debug1_wb_pc_o       = pc_q[1];
    assign debug1_wb_rf_wen_o   = {{(DEBUG_WEN_BITS-1){1'b0}}, we_q[1]};
    assign debug1_wb_rf_wnum_o  = waddr_q[1];
    assign debug1_wb_rf_wdata_o = wdata_q[1];

endmodule

`default_nettype wire

/* verilog/backend_glue_top.sv */
`timescale 1ns/1ns
`default_nettype none

module backend_glue_top #(
    parameter  int unsigned FTQ_DEPTH   = 8,
    localparam int unsigned FTQ_ID_BITS = $clog2(FTQ_DEPTH)
) (
    input  wire logic                                              clk,
    input  wire logic                                              reset_i,

    // Redirect sources
    input  wire logic                                              excp_flush_i,
    input  wire logic                                              excp_tlbrefill_i,
    input  wire logic                                              ertn_flush_i,
    input  wire logic                                              idle_flush_i,
    input  wire logic                                              fetch_flush_i,
    input  wire logic                                              ex_stall_i,
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]               branch_flag_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] branch_target_i,
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0][FTQ_ID_BITS-1:0] branch_ftq_id_i,
    input  wire logic [FTQ_ID_BITS-1:0]                            ctrl_ftq_id_i,
    input  wire backend_pkg::word_t                                csr_eentry_i,
    input  wire backend_pkg::word_t                                csr_tlbrentry_i,
    input  wire backend_pkg::word_t                                csr_era_i,
    input  wire backend_pkg::word_t                                idle_pc_i,
    output logic                                                   flush_o,
    output backend_pkg::word_t                                     next_pc_o,
    output logic [FTQ_ID_BITS-1:0]                                 flush_ftq_id_o,
    output logic [backend_pkg::ISSUE_WIDTH-1:0]                    branch_taken_o,

    // Memory lanes and data cache port
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]               lane_ce_i,
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]               lane_we_i,
    input  wire backend_pkg::byte_sel_t [backend_pkg::ISSUE_WIDTH-1:0] lane_sel_i,
    input  wire backend_pkg::mem_type_t [backend_pkg::ISSUE_WIDTH-1:0] lane_rd_type_i,
    input  wire backend_pkg::mem_type_t [backend_pkg::ISSUE_WIDTH-1:0] lane_wr_type_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] lane_addr_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] lane_wdata_i,
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]               wb_dcache_flush_i,
    output logic                                                   dcache_valid_o,
    output logic                                                   dcache_op_o,
    output backend_pkg::dcache_index_t                             dcache_index_o,
    output backend_pkg::dcache_offset_t                            dcache_offset_o,
    output backend_pkg::byte_sel_t                                 dcache_wstrb_o,
    output backend_pkg::word_t                                     dcache_wdata_o,
    output backend_pkg::mem_type_t                                 dcache_rd_type_o,
    output backend_pkg::mem_type_t                                 dcache_wr_type_o,
    output logic                                                   dcache_flush_o,

    // Write-back trace
    input  wire logic [backend_pkg::ISSUE_WIDTH-1:0]               wb_we_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] wb_pc_i,
    input  wire backend_pkg::reg_addr_t [backend_pkg::ISSUE_WIDTH-1:0] wb_waddr_i,
    input  wire backend_pkg::word_t [backend_pkg::ISSUE_WIDTH-1:0] wb_wdata_i,
    output backend_pkg::word_t                                     debug0_wb_pc_o,
    output logic [backend_pkg::DEBUG_WEN_BITS-1:0]                 debug0_wb_rf_wen_o,
    output backend_pkg::reg_addr_t                                 debug0_wb_rf_wnum_o,
    output backend_pkg::word_t                                     debug0_wb_rf_wdata_o,
    output backend_pkg::word_t                                     debug1_wb_pc_o,
    output logic [backend_pkg::DEBUG_WEN_BITS-1:0]                 debug1_wb_rf_wen_o,
    output backend_pkg::reg_addr_t                                 debug1_wb_rf_wnum_o,
    output backend_pkg::word_t                                     debug1_wb_rf_wdata_o
);

    // Frontend redirect
    redirect_sel #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) u_redirect_sel (
        .excp_flush_i     (excp_flush_i),
        .excp_tlbrefill_i (excp_tlbrefill_i),
        .ertn_flush_i     (ertn_flush_i),
        .idle_flush_i     (idle_flush_i),
        .fetch_flush_i    (fetch_flush_i),
        .ex_stall_i       (ex_stall_i),
        .branch_flag_i    (branch_flag_i),
        .branch_target_i  (branch_target_i),
        .branch_ftq_id_i  (branch_ftq_id_i),
        .ctrl_ftq_id_i    (ctrl_ftq_id_i),
        .csr_eentry_i     (csr_eentry_i),
        .csr_tlbrentry_i  (csr_tlbrentry_i),
        .csr_era_i        (csr_era_i),
        .idle_pc_i        (idle_pc_i),
        .flush_o          (flush_o),
        .next_pc_o        (next_pc_o),
        .flush_ftq_id_o   (flush_ftq_id_o),
        .branch_taken_o   (branch_taken_o)
    );

    // Single data cache port shared by both memory lanes
    lane_mem_merge u_lane_mem_merge (
        .lane_ce_i         (lane_ce_i),
        .lane_we_i         (lane_we_i),
        .lane_sel_i        (lane_sel_i),
        .lane_rd_type_i    (lane_rd_type_i),
        .lane_wr_type_i    (lane_wr_type_i),
        .lane_addr_i       (lane_addr_i),
        .lane_wdata_i      (lane_wdata_i),
        .wb_dcache_flush_i (wb_dcache_flush_i),
        .dcache_valid_o    (dcache_valid_o),
        .dcache_op_o       (dcache_op_o),
        .dcache_index_o    (dcache_index_o),
        .dcache_offset_o   (dcache_offset_o),
        .dcache_wstrb_o    (dcache_wstrb_o),
        .dcache_wdata_o    (dcache_wdata_o),
        .dcache_rd_type_o  (dcache_rd_type_o),
        .dcache_wr_type_o  (dcache_wr_type_o),
        .dcache_flush_o    (dcache_flush_o)
    );

    wb_debug_trace u_wb_debug_trace (
        .clk                  (clk),
        .reset_i              (reset_i),
        .wb_we_i              (wb_we_i),
        .wb_pc_i              (wb_pc_i),
        .wb_waddr_i           (wb_waddr_i),
        .wb_wdata_i           (wb_wdata_i),
        .debug0_wb_pc_o       (debug0_wb_pc_o),
        .debug0_wb_rf_wen_o   (debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o  (debug0_wb_rf_wnum_o),
        .debug0_wb_rf_wdata_o (debug0_wb_rf_wdata_o),
        .debug1_wb_pc_o       (debug1_wb_pc_o),
        .debug1_wb_rf_wen_o   (debug1_wb_rf_wen_o),
        .debug1_wb_rf_wnum_o  (debug1_wb_rf_wnum_o),
        .debug1_wb_rf_wdata_o (debug1_wb_rf_wdata_o)
    );

endmodule

`default_nettype wire

/* dv/tb_backend_glue.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_backend_glue;

    import backend_pkg::*;

    localparam int unsigned FTQ_DEPTH     = 8;
    localparam int unsigned FTQ_ID_BITS   = $clog2(FTQ_DEPTH);
    localparam int unsigned RUN_CYCLES    = 2000;
    localparam int unsigned COVER_TIMEOUT = 4000;    // Extra cycles to reach missing cases
    localparam int unsigned NUM_CASES     = 18;

    logic clk;
    logic reset_i;

    logic                                        excp_flush_i, excp_tlbrefill_i;
    logic                                        ertn_flush_i, idle_flush_i, fetch_flush_i;
    logic                                        ex_stall_i;
    logic [ISSUE_WIDTH-1:0]                      branch_flag_i;
    word_t [ISSUE_WIDTH-1:0]                     branch_target_i;
    logic [ISSUE_WIDTH-1:0][FTQ_ID_BITS-1:0]     branch_ftq_id_i;
    logic [FTQ_ID_BITS-1:0]                      ctrl_ftq_id_i;
    word_t                                       csr_eentry_i, csr_tlbrentry_i;
    word_t                                       csr_era_i, idle_pc_i;
    logic                                        flush_o;
    word_t                                       next_pc_o;
    logic [FTQ_ID_BITS-1:0]                      flush_ftq_id_o;
    logic [ISSUE_WIDTH-1:0]                      branch_taken_o;

    logic [ISSUE_WIDTH-1:0]                      lane_ce_i, lane_we_i, wb_dcache_flush_i;
    byte_sel_t [ISSUE_WIDTH-1:0]                 lane_sel_i;
    mem_type_t [ISSUE_WIDTH-1:0]                 lane_rd_type_i, lane_wr_type_i;
    word_t [ISSUE_WIDTH-1:0]                     lane_addr_i, lane_wdata_i;
    logic                                        dcache_valid_o, dcache_op_o, dcache_flush_o;
    dcache_index_t                               dcache_index_o;
    dcache_offset_t                              dcache_offset_o;
    byte_sel_t                                   dcache_wstrb_o;
    word_t                                       dcache_wdata_o;
    mem_type_t                                   dcache_rd_type_o, dcache_wr_type_o;

    logic [ISSUE_WIDTH-1:0]                      wb_we_i;
    word_t [ISSUE_WIDTH-1:0]                     wb_pc_i, wb_wdata_i;
    reg_addr_t [ISSUE_WIDTH-1:0]                 wb_waddr_i;
    word_t                                       debug0_wb_pc_o, debug0_wb_rf_wdata_o;
    word_t                                       debug1_wb_pc_o, debug1_wb_rf_wdata_o;
    logic [DEBUG_WEN_BITS-1:0]                   debug0_wb_rf_wen_o, debug1_wb_rf_wen_o;
    reg_addr_t                                   debug0_wb_rf_wnum_o, debug1_wb_rf_wnum_o;

    logic [31:0]            lfsr_state;
    logic [NUM_CASES-1:0]   hit;    // Antecedents seen so far
    logic [NUM_CASES-1:0]   cases;
    logic                   ctrl_flush;
    logic [ISSUE_WIDTH-1:0] br_taken;
    word_t                  exp_addr, exp_wdata;
    mem_type_t              exp_rd_type, exp_wr_type;
    byte_sel_t              exp_wstrb;
    logic                   reset_q;
    logic                   first_after_reset;
    logic [ISSUE_WIDTH-1:0] prev_we;
    word_t [ISSUE_WIDTH-1:0]     prev_pc, prev_wdata;
    reg_addr_t [ISSUE_WIDTH-1:0] prev_waddr;

    backend_glue_top #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) u_backend_glue_top (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        stop_run();
    endtask

    task automatic drive_inputs();
        logic [3:0] kind;
        logic [1:0] lane;
        kind = rand_bits(4);
        {excp_flush_i, excp_tlbrefill_i, ertn_flush_i, idle_flush_i, fetch_flush_i} = '0;
        case (kind)    // Mostly quiet, single sources favoured
            4'd10: excp_flush_i = 1'b1;
            4'd11: begin
                excp_flush_i     = 1'b1;
                excp_tlbrefill_i = 1'b1;
            end
            4'd12: ertn_flush_i = 1'b1;
            4'd13: idle_flush_i = 1'b1;
            4'd14: fetch_flush_i = 1'b1;
            4'd15: begin
                {excp_flush_i, ertn_flush_i, idle_flush_i, fetch_flush_i} = rand_bits(4);
                excp_tlbrefill_i = excp_flush_i && (rand_bits(1) != 0);
            end
            default: ;
        endcase
        ex_stall_i      = (rand_bits(2) == 0);
        branch_flag_i   = rand_bits(2);
        ctrl_ftq_id_i   = rand_bits(FTQ_ID_BITS);
        csr_eentry_i    = rand_bits(32);
        csr_tlbrentry_i = rand_bits(32);
        csr_era_i       = rand_bits(32);
        idle_pc_i       = rand_bits(32);

        lane      = rand_bits(2);
        lane_ce_i = (lane == 2'd1) ? 2'b01 : (lane == 2'd2) ? 2'b10 : 2'b00;
        lane_we_i = lane_ce_i & rand_bits(2);
        wb_dcache_flush_i = (rand_bits(2) == 0) ? rand_bits(2) : '0;
        wb_we_i   = rand_bits(2);
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            branch_target_i[i] = rand_bits(32);
            branch_ftq_id_i[i] = rand_bits(FTQ_ID_BITS);
            lane_sel_i[i]      = rand_bits(BYTE_SEL_BITS);
            lane_rd_type_i[i]  = rand_bits(MEM_TYPE_BITS);
            lane_wr_type_i[i]  = rand_bits(MEM_TYPE_BITS);
            lane_addr_i[i]     = rand_bits(32);
            lane_wdata_i[i]    = rand_bits(32);
            wb_pc_i[i]         = rand_bits(32);
            wb_waddr_i[i]      = rand_bits(REG_ADDR_BITS);
            wb_wdata_i[i]      = rand_bits(32);
        end
    endtask

    // Reference view of the rules
    assign ctrl_flush  = excp_flush_i | ertn_flush_i | idle_flush_i | fetch_flush_i;
    assign br_taken    = ex_stall_i ? '0 : branch_flag_i;
    assign exp_addr    = lane_ce_i[0] ? lane_addr_i[0] : lane_ce_i[1] ? lane_addr_i[1] : '0;
    assign exp_rd_type = lane_ce_i[0] ? lane_rd_type_i[0] :
                         lane_ce_i[1] ? lane_rd_type_i[1] : '0;
    assign exp_wr_type = lane_ce_i[0] ? lane_wr_type_i[0] :
                         lane_ce_i[1] ? lane_wr_type_i[1] : '0;
    assign exp_wstrb   = lane_we_i[0] ? lane_sel_i[0] : lane_we_i[1] ? lane_sel_i[1] : '0;
    assign exp_wdata   = lane_we_i[0] ? lane_wdata_i[0] : lane_we_i[1] ? lane_wdata_i[1] : '0;
    assign first_after_reset = reset_q & ~reset_i;

    assign cases = {first_after_reset, wb_we_i[1], wb_we_i[0], |wb_dcache_flush_i,
                    lane_we_i[1], lane_we_i[0], lane_ce_i == '0, lane_ce_i[1], lane_ce_i[0],
                    ex_stall_i & (|branch_flag_i),
                    !ctrl_flush && br_taken == '0,
                    !ctrl_flush && br_taken == 2'b10,
                    !ctrl_flush && br_taken[0],
                    !excp_flush_i && !ertn_flush_i && !idle_flush_i && fetch_flush_i,
                    !excp_flush_i && !ertn_flush_i && idle_flush_i,
                    !excp_flush_i && ertn_flush_i,
                    excp_flush_i && excp_tlbrefill_i,
                    excp_flush_i && !excp_tlbrefill_i};

    always @(posedge clk) begin
        reset_q    <= reset_i;
        prev_we    <= reset_i ? '0 : wb_we_i;    // Debug enables restart inactive
        prev_pc    <= wb_pc_i;
        prev_waddr <= wb_waddr_i;
        prev_wdata <= wb_wdata_i;
        hit        <= reset_i ? '0 : (hit | cases);
    end

    a_excp_pc: assert property (@(posedge clk) cases[0] |-> next_pc_o == csr_eentry_i)
        else value_error("next_pc_o", $sampled(next_pc_o), $sampled(csr_eentry_i));
    a_refill_pc: assert property (@(posedge clk) cases[1] |-> next_pc_o == csr_tlbrentry_i)
        else value_error("next_pc_o", $sampled(next_pc_o), $sampled(csr_tlbrentry_i));
    a_ertn_pc: assert property (@(posedge clk) cases[2] |-> next_pc_o == csr_era_i)
        else value_error("next_pc_o", $sampled(next_pc_o), $sampled(csr_era_i));
    a_idle_pc: assert property (@(posedge clk) cases[3] |-> next_pc_o == idle_pc_i)
        else value_error("next_pc_o", $sampled(next_pc_o), $sampled(idle_pc_i));
    a_refetch_pc: assert property (@(posedge clk)
        cases[4] |-> next_pc_o == word_t'(idle_pc_i + INSTR_BYTES))
        else value_error("next_pc_o", $sampled(next_pc_o), $sampled(idle_pc_i) + INSTR_BYTES);
    a_br0_pc: assert property (@(posedge clk) cases[5] |-> next_pc_o == branch_target_i[0])
        else value_error("next_pc_o", $sampled(next_pc_o), $sampled(branch_target_i[0]));
    a_br1_pc: assert property (@(posedge clk) cases[6] |-> next_pc_o == branch_target_i[1])
        else value_error("next_pc_o", $sampled(next_pc_o), $sampled(branch_target_i[1]));
    a_quiet_pc: assert property (@(posedge clk) cases[7] |-> next_pc_o == '0)
        else value_error("next_pc_o", $sampled(next_pc_o), 32'h0);

    a_flush: assert property (@(posedge clk) flush_o == (ctrl_flush || br_taken != '0))
        else value_error("flush_o", $sampled(flush_o), $sampled(ctrl_flush || br_taken != '0));
    a_taken: assert property (@(posedge clk) branch_taken_o == br_taken)
        else value_error("branch_taken_o", $sampled(branch_taken_o), $sampled(br_taken));

    a_ctrl_id: assert property (@(posedge clk) ctrl_flush |-> flush_ftq_id_o == ctrl_ftq_id_i)
        else value_error("flush_ftq_id_o", $sampled(flush_ftq_id_o), $sampled(ctrl_ftq_id_i));
    a_br0_id: assert property (@(posedge clk) cases[5] |-> flush_ftq_id_o == branch_ftq_id_i[0])
        else value_error("flush_ftq_id_o", $sampled(flush_ftq_id_o),
                         $sampled(branch_ftq_id_i[0]));
    a_br1_id: assert property (@(posedge clk) cases[6] |-> flush_ftq_id_o == branch_ftq_id_i[1])
        else value_error("flush_ftq_id_o", $sampled(flush_ftq_id_o),
                         $sampled(branch_ftq_id_i[1]));
    a_quiet_id: assert property (@(posedge clk) cases[7] |-> flush_ftq_id_o == '0)
        else value_error("flush_ftq_id_o", $sampled(flush_ftq_id_o), 32'h0);

    // Data cache port
    a_valid: assert property (@(posedge clk) dcache_valid_o == (|lane_ce_i))
        else value_error("dcache_valid_o", $sampled(dcache_valid_o), $sampled(|lane_ce_i));
    a_op: assert property (@(posedge clk) dcache_op_o == (|lane_we_i))
        else value_error("dcache_op_o", $sampled(dcache_op_o), $sampled(|lane_we_i));
    a_dflush: assert property (@(posedge clk) dcache_flush_o == (|wb_dcache_flush_i))
        else value_error("dcache_flush_o", $sampled(dcache_flush_o),
                         $sampled(|wb_dcache_flush_i));
    a_offset: assert property (@(posedge clk)
        dcache_offset_o == exp_addr[DCACHE_OFFSET_BITS-1:0])
        else value_error("dcache_offset_o", $sampled(dcache_offset_o),
                         $sampled(exp_addr[DCACHE_OFFSET_BITS-1:0]));
    a_index: assert property (@(posedge clk)
        dcache_index_o == exp_addr[DCACHE_OFFSET_BITS +: DCACHE_INDEX_BITS])
        else value_error("dcache_index_o", $sampled(dcache_index_o),
                         $sampled(exp_addr[DCACHE_OFFSET_BITS +: DCACHE_INDEX_BITS]));
    a_rd_type: assert property (@(posedge clk) dcache_rd_type_o == exp_rd_type)
        else value_error("dcache_rd_type_o", $sampled(dcache_rd_type_o), $sampled(exp_rd_type));
    a_wr_type: assert property (@(posedge clk) dcache_wr_type_o == exp_wr_type)
        else value_error("dcache_wr_type_o", $sampled(dcache_wr_type_o), $sampled(exp_wr_type));
    a_wstrb: assert property (@(posedge clk) dcache_wstrb_o == exp_wstrb)
        else value_error("dcache_wstrb_o", $sampled(dcache_wstrb_o), $sampled(exp_wstrb));
    a_wdata: assert property (@(posedge clk) dcache_wdata_o == exp_wdata)
        else value_error("dcache_wdata_o", $sampled(dcache_wdata_o), $sampled(exp_wdata));

    // Debug trace, one cycle behind write-back
    a_wen_reset: assert property (@(posedge clk)
        first_after_reset |-> {debug1_wb_rf_wen_o, debug0_wb_rf_wen_o} == '0)
        else value_error("debug write enables",
                         $sampled({debug1_wb_rf_wen_o, debug0_wb_rf_wen_o}), 32'h0);
    a_wen0: assert property (@(posedge clk) disable iff (reset_i)
        debug0_wb_rf_wen_o == DEBUG_WEN_BITS'(prev_we[0]))
        else value_error("debug0_wb_rf_wen_o", $sampled(debug0_wb_rf_wen_o), $sampled(prev_we[0]));
    a_wen1: assert property (@(posedge clk) disable iff (reset_i)
        debug1_wb_rf_wen_o == DEBUG_WEN_BITS'(prev_we[1]))
        else value_error("debug1_wb_rf_wen_o", $sampled(debug1_wb_rf_wen_o), $sampled(prev_we[1]));
    a_pc0: assert property (@(posedge clk) disable iff (reset_i) debug0_wb_pc_o == prev_pc[0])
        else value_error("debug0_wb_pc_o", $sampled(debug0_wb_pc_o), $sampled(prev_pc[0]));
    a_pc1: assert property (@(posedge clk) disable iff (reset_i) debug1_wb_pc_o == prev_pc[1])
        else value_error("debug1_wb_pc_o", $sampled(debug1_wb_pc_o), $sampled(prev_pc[1]));
    a_wnum0: assert property (@(posedge clk) disable iff (reset_i)
        debug0_wb_rf_wnum_o == prev_waddr[0])
        else value_error("debug0_wb_rf_wnum_o", $sampled(debug0_wb_rf_wnum_o),
                         $sampled(prev_waddr[0]));
    a_wnum1: assert property (@(posedge clk) disable iff (reset_i)
        debug1_wb_rf_wnum_o == prev_waddr[1])
        else value_error("debug1_wb_rf_wnum_o", $sampled(debug1_wb_rf_wnum_o),
                         $sampled(prev_waddr[1]));
    a_wdata0: assert property (@(posedge clk) disable iff (reset_i)
        debug0_wb_rf_wdata_o == prev_wdata[0])
        else value_error("debug0_wb_rf_wdata_o", $sampled(debug0_wb_rf_wdata_o),
                         $sampled(prev_wdata[0]));
    a_wdata1: assert property (@(posedge clk) disable iff (reset_i)
        debug1_wb_rf_wdata_o == prev_wdata[1])
        else value_error("debug1_wb_rf_wdata_o", $sampled(debug1_wb_rf_wdata_o),
                         $sampled(prev_wdata[1]));

    initial begin
        int waited;
        lfsr_state = 32'h0516_3f33;
        clk        = 1'b0;
        reset_i    = 1'b1;
        drive_inputs();
        wb_we_i    = '1;    // Writes during reset must not reach the debug enables
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;
        drive_inputs();
        for (int n = 0; n < RUN_CYCLES; n++) begin
            @(posedge clk);
            #1;
            drive_inputs();
        end

        // Keep stepping until every antecedent was reached
        waited = 0;
        while (hit != '1 && waited < COVER_TIMEOUT) begin
            @(posedge clk);
            #1;
            drive_inputs();
            waited++;
        end
        if (hit != '1) begin
            $display("Some checks were never exercised, missing cases %b", ~hit);
            stop_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
verilog/backend_pkg.sv
verilog/redirect_sel.sv
verilog/lane_mem_merge.sv
verilog/wb_debug_trace.sv
verilog/backend_glue_top.sv
dv/tb_backend_glue.sv

/* Bender.yml */
package:
  name: backend_glue

sources:
  - verilog/backend_pkg.sv
  - verilog/redirect_sel.sv
  - verilog/lane_mem_merge.sv
  - verilog/wb_debug_trace.sv
  - verilog/backend_glue_top.sv
  - target: test
    files:
      - dv/tb_backend_glue.sv
